//--- flist.f
iCachePkg.sv
iCacheSram.sv
iCacheCtrl.sv
iCacheTop.sv
iMemModel.sv
iCacheTb.sv

//--- iCacheCtrl.sv
// Instruction fetch controller with cache lookup, miss request, block fill and word select
`timescale 1ns/100ps
`default_nettype none

module iCacheCtrl
        import iCachePkg::*;
#(
        parameter int NumSets = DefNumSets,
        parameter int NumWays = DefNumWays
) (
        input  logic                     clk,
        input  logic                     arstN,
        input  logic                     fetchReq,
        input  logic [AddrBits-1:0]      fetchAddr,
        output logic                     fetchReady,
        output logic                     instrValid,
        output logic [WordBits-1:0]      instr,
        output logic                     instrHit,
        output logic                     ren,
        output logic                     memWen,
        output logic [BlockAddrBits-1:0] blockAddr,
        output logic [BlockBits-1:0]     dataIn,
        input  logic                     hit,
        input  logic [BlockBits-1:0]     dataOut,
        output logic                     memReq,
        output logic [BlockAddrBits-1:0] memBlockAddr,
        input  logic                     memValid,
        input  logic [BlockBits-1:0]     memData
);

        typedef enum logic [2:0] {
                Idle,
                Lookup,
                Miss,
                Fill,
                Relookup
        } stateT;

        stateT state;

        // Lookup spends one cycle on ren and one on the SRAM result
        logic probed;

        // Set once the current fetch has missed
        logic missQ;

        // Fetch address and the block returned by memory
        logic [AddrBits-1:0]  addrQ;
        logic [BlockBits-1:0] memBlock;

        logic                 accept;
        logic                 respond;
        logic [BlockBits-1:0] selBlock;
        logic [WordBits-1:0]  wordSel;

        // Geometry limits, at least one set-index bit is needed
        if (NumSets < 2 || NumSets > MaxSets || (NumSets & (NumSets - 1)) != 0) begin : gBadSets
                $error("iCacheCtrl: NumSets must be a power of two from 2 to %0d", MaxSets);
        end
        if (NumWays < 2 || NumWays > MaxWays) begin : gBadWays
                $error("iCacheCtrl: NumWays must be from 2 to %0d", MaxWays);
        end

        assign fetchReady = (state == Idle);
        assign accept     = fetchReq && fetchReady;

        // SRAM side
        assign ren       = (state == Lookup && !probed) || (state == Relookup);
        assign memWen    = (state == Fill);
        assign blockAddr = addrQ[AddrBits-1:OffsetBits];
        assign dataIn    = memBlock;

        // Memory side, held steady for the whole miss
        assign memReq       = (state == Miss);
        assign memBlockAddr = addrQ[AddrBits-1:OffsetBits];

        // Result on a probed hit or at the end of a miss
        assign respond = (state == Lookup && probed && hit) || (state == Relookup);

        // A miss returns the word straight from the fetched block
        assign selBlock = (state == Relookup) ? memBlock : dataOut;
        assign wordSel  = selBlock[addrQ[OffsetBits-1:0] * WordBits +: WordBits];

        // Fetch FSM
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        state      <= Idle;
                        probed     <= 1'b0;
                        missQ      <= 1'b0;
                        instrValid <= 1'b0;
                end else begin
                        instrValid <= respond;
                        case (state)
                                Idle: begin
                                        if (accept) begin
                                                state  <= Lookup;
                                                probed <= 1'b0;
                                                missQ  <= 1'b0;
                                        end
                                end
                                Lookup: begin
                                        probed <= 1'b1;
                                        // SRAM result is valid once probed
                                        if (probed) begin
                                                state <= hit ? Idle : Miss;
                                                missQ <= !hit;
                                        end
                                end
                                Miss: begin
                                        if (memValid) begin
                                                state <= Fill;
                                        end
                                end
                                Fill: begin
                                        state <= Relookup;
                                end
                                Relookup: begin
                                        state <= Idle;
                                end
                                default: begin
                                        state <= Idle;
                                end
                        endcase
                end
        end

        // Address, fill block and result word
        always_ff @(posedge clk) begin
                if (accept) begin
                        addrQ <= fetchAddr;
                end
                if (state == Miss && memValid) begin
                        memBlock <= memData;
                end
                if (respond) begin
                        instr    <= wordSel;
                        instrHit <= !missQ;
                end
        end

        // Core waits for fetchReady before the next fetch
        assert property (@(posedge clk) disable iff (!arstN) fetchReq |-> fetchReady)
                else $error("iCacheCtrl: fetchReq while not ready");

        // Memory only answers an open request
        assert property (@(posedge clk) disable iff (!arstN) memValid |-> memReq)
                else $error("iCacheCtrl: memValid without memReq");

endmodule

`default_nettype wire

//--- iCachePkg.sv
// Instruction cache package with shared geometry and the widths derived from it
`default_nettype none

package iCachePkg;

        // One instruction word
        localparam int WordBits = 32;

        // Words held by one cache block
        localparam int BlockWords = 4;

        // Full block as seen on the fill and lookup paths
        localparam int BlockBits = WordBits * BlockWords;

        // Word select within a block, 2 bits for 4 words
        localparam int OffsetBits = $clog2(BlockWords);

        // Word address from the core
        localparam int AddrBits = 10;

        // Block address is tag and set index together
        localparam int BlockAddrBits = AddrBits - OffsetBits;

        // Default shape, the top level may override it
        localparam int DefNumSets = 2;
        localparam int DefNumWays = 4;

        // Largest shape the arrays and LRU ages are sized for
        localparam int MaxSets = 8;
        localparam int MaxWays = 8;

        // Set index and tag split for the default shape
        // Modules redo this split from their own NumSets
        localparam int DefSetBits = $clog2(DefNumSets);
        localparam int DefTagBits = BlockAddrBits - DefSetBits;

endpackage

`default_nettype wire

//--- iCacheSram.sv
// Set-associative instruction cache arrays with registered lookup, block fill and true LRU
`timescale 1ns/100ps
`default_nettype none

module iCacheSram
        import iCachePkg::*;
#(
        parameter int NumSets = DefNumSets,
        parameter int NumWays = DefNumWays
) (
        input  logic                     clk,
        input  logic                     arstN,
        input  logic                     ren,
        input  logic                     memWen,
        input  logic [BlockAddrBits-1:0] blockAddr,
        input  logic [BlockBits-1:0]     dataIn,
        output logic                     hit,
        output logic [BlockBits-1:0]     dataOut
);

        // Block address split into tag and set index
        localparam int SetBits = $clog2(NumSets);
        localparam int TagBits = BlockAddrBits - SetBits;

        // Way number, also the width of an LRU age
        localparam int WayBits = $clog2(NumWays);

        // Valid bits and ages are control state
        logic [NumWays-1:0] validMem [NumSets];
        // Age 0 is the most recently used way
        logic [WayBits-1:0] ageMem [NumSets][NumWays];

        // Tag and data arrays
        logic [TagBits-1:0]   tagMem  [NumSets][NumWays];
        logic [BlockBits-1:0] dataMem [NumSets][NumWays];

        logic [SetBits-1:0] setIdx;
        logic [TagBits-1:0] tagIdx;

        // Parallel compare results
        logic [NumWays-1:0] matchVec;
        logic               anyMatch;
        logic [WayBits-1:0] matchWay;

        // Lowest invalid way of the set
        logic               anyFree;
        logic [WayBits-1:0] freeWay;

        // Oldest valid way of the set
        logic [WayBits-1:0] lruWay;
        logic [WayBits-1:0] lruAge;

        // Fill target and the age that sets which ways grow older
        logic [WayBits-1:0] victimWay;
        logic [WayBits-1:0] refAge;

        assign setIdx = blockAddr[SetBits-1:0];
        assign tagIdx = blockAddr[BlockAddrBits-1:SetBits];

        // Tag compare across all ways of the addressed set
        always_comb begin
                matchVec = '0;
                matchWay = '0;
                anyFree  = 1'b0;
                freeWay  = '0;
                // Scan downward so the lowest way wins
                for (int w = NumWays - 1; w >= 0; w--) begin
                        matchVec[w] = validMem[setIdx][w] && (tagMem[setIdx][w] == tagIdx);
                        if (matchVec[w]) begin
                                matchWay = WayBits'(w);
                        end
                        if (!validMem[setIdx][w]) begin
                                anyFree = 1'b1;
                                freeWay = WayBits'(w);
                        end
                end
        end

        assign anyMatch = |matchVec;

        // Oldest way, ages of valid ways are all distinct
        always_comb begin
                lruWay = '0;
                lruAge = '0;
                for (int w = 0; w < NumWays; w++) begin
                        if (ageMem[setIdx][w] > lruAge) begin
                                lruAge = ageMem[setIdx][w];
                                lruWay = WayBits'(w);
                        end
                end
        end

        // Victim is the matching way, then a free way, then the LRU way
        always_comb begin
                if (anyMatch) begin
                        victimWay = matchWay;
                end else if (anyFree) begin
                        victimWay = freeWay;
                end else begin
                        victimWay = lruWay;
                end
                // A free victim ages every valid way of the set
                refAge = validMem[setIdx][victimWay] ? ageMem[setIdx][victimWay]
                                                     : WayBits'(NumWays - 1);
        end

        // Lookup result
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        hit <= 1'b0;
                end else begin
                        // Hit holds until the next lookup
                        if (ren) begin
                                hit <= anyMatch;
                        end
                end
        end

        // Lookup payload
        always_ff @(posedge clk) begin
                if (ren) begin
                        dataOut <= dataMem[setIdx][matchWay];
                end
        end

        // Block fill into the victim way
        always_ff @(posedge clk) begin
                if (memWen) begin
                        tagMem[setIdx][victimWay]  <= tagIdx;
                        dataMem[setIdx][victimWay] <= dataIn;
                end
        end

        // Valid bits and true LRU ages
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        for (int s = 0; s < NumSets; s++) begin
                                validMem[s] <= '0;
                                for (int w = 0; w < NumWays; w++) begin
                                        ageMem[s][w] <= '0;
                                end
                        end
                end else if (memWen) begin
                        validMem[setIdx][victimWay] <= 1'b1;
                        for (int w = 0; w < NumWays; w++) begin
                                if (WayBits'(w) == victimWay) begin
                                        ageMem[setIdx][w] <= '0;
                                end else if (validMem[setIdx][w] &&
                                             ageMem[setIdx][w] < refAge) begin
                                        ageMem[setIdx][w] <= ageMem[setIdx][w] + 1'b1;
                                end
                        end
                end else if (ren && anyMatch) begin
                        // Ways younger than the hit way move one step older
                        for (int w = 0; w < NumWays; w++) begin
                                if (WayBits'(w) == matchWay) begin
                                        ageMem[setIdx][w] <= '0;
                                end else if (validMem[setIdx][w] &&
                                             ageMem[setIdx][w] < ageMem[setIdx][matchWay]) begin
                                        ageMem[setIdx][w] <= ageMem[setIdx][w] + 1'b1;
                                end
                        end
                end
        end

        // Controller never overlaps a lookup with a fill
        assert property (@(posedge clk) disable iff (!arstN) !(ren && memWen))
                else $error("iCacheSram: ren and memWen high together");

        // A tag lives in at most one way of a set
        for (genvar s = 0; s < NumSets; s++) begin : gSetChk
                for (genvar a = 0; a < NumWays; a++) begin : gWayA
                        for (genvar b = a + 1; b < NumWays; b++) begin : gWayB
                                assert property (@(posedge clk) disable iff (!arstN)
                                        !(validMem[s][a] && validMem[s][b] &&
                                          tagMem[s][a] == tagMem[s][b]))
                                        else $error("iCacheSram: duplicate tag in set %0d", s);
                        end
                end
        end

endmodule

`default_nettype wire

//--- iCacheTb.sv
// Instruction cache testbench with LRU reference model, response compare and watchdog
`timescale 1ns/100ps
`default_nettype none

module iCacheTb
        import iCachePkg::*;
();

        localparam int NumSets     = DefNumSets;
        localparam int NumWays     = DefNumWays;
        localparam int ClkPeriod   = 4;
        localparam int RandFetches = 40;
        // Fetches of all tests together, worst miss in cycles, slack for resets
        localparam int TotalFetches = 21 + RandFetches;
        localparam int WorstCycles  = 20;
        localparam int MarginCycles = 50;

        logic                     clk;
        logic                     arstN;
        logic                     fetchReq;
        logic [AddrBits-1:0]      fetchAddr;
        logic                     fetchReady;
        logic                     instrValid;
        logic [WordBits-1:0]      instr;
        logic                     instrHit;
        logic                     memReq;
        logic [BlockAddrBits-1:0] memBlockAddr;
        logic                     memValid;
        logic [BlockBits-1:0]     memData;

        // Outstanding fetch and what it should return
        logic                pending;
        logic                expHit;
        logic [WordBits-1:0] expInstr;
        string               curName;
        int                  acceptEdge;
        int                  cycleCnt;
        int                  doneCount;

        // Recency order per set, rank 0 is the most recent block
        logic [BlockAddrBits-1:0] rankBlk [NumSets][NumWays];
        int                       rankCount [NumSets];

        int          errorCount;
        int          checkCount;
        int          testIdx;
        int          testsFailed;
        int          testErrStart;
        string       testName;
        logic [31:0] rndState;

        iCacheTop #(
                .NumSets (NumSets),
                .NumWays (NumWays)
        ) u_dut (
                .clk          (clk),
                .arstN        (arstN),
                .fetchReq     (fetchReq),
                .fetchAddr    (fetchAddr),
                .fetchReady   (fetchReady),
                .instrValid   (instrValid),
                .instr        (instr),
                .instrHit     (instrHit),
                .memReq       (memReq),
                .memBlockAddr (memBlockAddr),
                .memValid     (memValid),
                .memData      (memData)
        );

        iMemModel u_mem (
                .clk          (clk),
                .arstN        (arstN),
                .memReq       (memReq),
                .memBlockAddr (memBlockAddr),
                .memValid     (memValid),
                .memData      (memData)
        );

        initial begin
                clk = 1'b0;
                forever #(ClkPeriod / 2) clk = ~clk;
        end

        function automatic logic [31:0] lcgStep(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        // Memory content: marker bits around the address and its inverse
        function automatic logic [WordBits-1:0] memWord(input logic [AddrBits-1:0] a);
                logic [AddrBits-1:0] inv;
                inv = ~a;
                return 32'hB4000013 | (32'(a) << 16) | (32'(inv) << 6);
        endfunction

        // Predicts hit or miss and moves the block to the front of its set
        function automatic logic refLookup(input logic [AddrBits-1:0] a);
                logic [BlockAddrBits-1:0] blk;
                int                       s;
                int                       pos;
                int                       last;
                blk = a[AddrBits-1:OffsetBits];
                s   = blk % NumSets;
                pos = -1;
                for (int r = 0; r < rankCount[s]; r++) begin
                        if (rankBlk[s][r] == blk) begin
                                pos = r;
                        end
                end
                // A miss in a full set drops the last rank
                if (pos < 0) begin
                        if (rankCount[s] < NumWays) begin
                                rankCount[s]++;
                        end
                        last = rankCount[s] - 1;
                end else begin
                        last = pos;
                end
                for (int r = last; r > 0; r--) begin
                        rankBlk[s][r] = rankBlk[s][r-1];
                end
                rankBlk[s][0] = blk;
                return pos >= 0;
        endfunction

        task automatic checkValue(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                checkCount++;
                if (expected !== actual) begin
                        errorCount++;
                        $display("** Error: %s, %s expected %0h actual %0h",
                                 testName, name, expected, actual);
                end
        endtask

        task automatic startTest(input string name);
                testIdx++;
                testName     = name;
                testErrStart = errorCount;
        endtask

        task automatic finishTest();
                if (errorCount == testErrStart) begin
                        $display("Test %0d %s: ok", testIdx, testName);
                end else begin
                        testsFailed++;
                        $display("Test %0d %s: FAILED with %0d errors", testIdx, testName,
                                 errorCount - testErrStart);
                end
        endtask

        // Reset also empties the reference model
        task automatic applyReset();
                @(posedge clk);
                arstN <= 1'b0;
                repeat (2) @(posedge clk);
                arstN <= 1'b1;
                for (int s = 0; s < NumSets; s++) begin
                        rankCount[s] = 0;
                end
        endtask

        task automatic checkIdle(input string name);
                @(posedge clk);
                checkValue({name, " fetchReady"}, 32'd1, 32'(fetchReady));
                checkValue({name, " instrValid"}, 32'd0, 32'(instrValid));
                checkValue({name, " memReq"}, 32'd0, 32'(memReq));
        endtask

        // One fetch, waits for the compare process to see its result
        task automatic doFetch(input string name, input logic [AddrBits-1:0] a);
                int                       target;
                logic                     sawMem;
                logic [BlockAddrBits-1:0] seenBlk;
                target  = doneCount + 1;
                sawMem  = 1'b0;
                seenBlk = '0;
                do @(posedge clk); while (!fetchReady);
                expHit   = refLookup(a);
                expInstr = memWord(a);
                curName  = name;
                pending  = 1'b1;
                fetchReq  <= 1'b1;
                fetchAddr <= a;
                @(posedge clk);
                acceptEdge = cycleCnt;
                fetchReq  <= 1'b0;
                do begin
                        @(posedge clk);
                        if (memReq) begin
                                sawMem  = 1'b1;
                                seenBlk = memBlockAddr;
                        end
                end while (doneCount < target);
                pending = 1'b0;
                // A hit must not touch memory, a miss asks for its own block
                if (expHit) begin
                        checkValue({name, " memReq"}, 32'd0, 32'(sawMem));
                end else begin
                        checkValue({name, " memBlockAddr"}, 32'(a[AddrBits-1:OffsetBits]),
                                   32'(seenBlk));
                end
        endtask

        // Compare process, sees outputs as they were before each edge
        always @(posedge clk) begin
                int lat;
                cycleCnt <= cycleCnt + 1;
                if (arstN && instrValid) begin
                        if (!pending) begin
                                checkValue("unexpected instrValid", 32'd0, 32'd1);
                        end else begin
                                checkValue({curName, " instr"}, expInstr, instr);
                                checkValue({curName, " instrHit"}, 32'(expHit), 32'(instrHit));
                                // Hit result two cycles after acceptance
                                if (expHit) begin
                                        lat = cycleCnt - 1 - acceptEdge;
                                        checkValue({curName, " latency"}, 32'd2, lat);
                                end
                                doneCount <= doneCount + 1;
                        end
                end
        end

        initial begin
                #(ClkPeriod * (TotalFetches * WorstCycles + MarginCycles));
                $display("Watchdog expired, a fetch never completed");
                $display("Some tests failed");
                $finish;
        end

        initial begin
                arstN      = 1'b0;
                fetchReq   = 1'b0;
                fetchAddr  = '0;
                pending    = 1'b0;
                expHit     = 1'b0;
                expInstr   = '0;
                acceptEdge = 0;
                cycleCnt   = 0;
                doneCount  = 0;
                errorCount = 0;
                checkCount = 0;
                testIdx    = 0;
                testsFailed = 0;
                rndState   = 32'h262c788e;
                for (int s = 0; s < NumSets; s++) begin
                        rankCount[s] = 0;
                end
                repeat (2) @(posedge clk);
                arstN <= 1'b1;

                startTest("reset and first miss");
                checkIdle("after reset");
                doFetch("first miss", 10'h035);
                finishTest();

                startTest("repeat hit");
                doFetch("repeat hit", 10'h035);
                finishTest();

                startTest("block words");
                doFetch("word 0", 10'h034);
                doFetch("word 2", 10'h036);
                doFetch("word 3", 10'h037);
                finishTest();

                // Set 0 blocks 0x10 to 0x16, then 0x18 pushes out 0x10
                startTest("lru eviction");
                for (int i = 0; i < 4; i++) begin
                        doFetch("lru fill", AddrBits'(10'h040 + 8 * i));
                end
                doFetch("touch 1", 10'h049);
                doFetch("touch 2", 10'h052);
                doFetch("touch 3", 10'h05B);
                doFetch("fifth tag", 10'h060);
                doFetch("touched 1", 10'h048);
                doFetch("touched 2", 10'h050);
                doFetch("touched 3", 10'h058);
                doFetch("evicted", 10'h041);
                finishTest();

                // Low addresses only, so hits and misses both occur
                startTest("random stream");
                repeat (RandFetches) begin
                        rndState = lcgStep(rndState);
                        doFetch("random", AddrBits'(rndState[21:16]));
                end
                finishTest();

                startTest("mid-run reset");
                doFetch("before reset", 10'h0A0);
                doFetch("before reset hit", 10'h0A1);
                applyReset();
                checkIdle("after mid reset");
                doFetch("after reset", 10'h0A1);
                doFetch("old block", 10'h035);
                finishTest();

                $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                         testIdx, testsFailed, checkCount, errorCount);
                if (errorCount == 0) begin
                        $display("All tests passed");
                end else begin
                        $display("Some tests failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- iCacheTop.sv
// Instruction cache top level joining the fetch controller and the cache arrays
`timescale 1ns/100ps
`default_nettype none

module iCacheTop
        import iCachePkg::*;
#(
        parameter int NumSets = DefNumSets,
        parameter int NumWays = DefNumWays
) (
        input  logic                     clk,
        input  logic                     arstN,
        // Fetch side
        input  logic                     fetchReq,
        input  logic [AddrBits-1:0]      fetchAddr,
        output logic                     fetchReady,
        // Result side
        output logic                     instrValid,
        output logic [WordBits-1:0]      instr,
        output logic                     instrHit,
        // Instruction memory side
        output logic                     memReq,
        output logic [BlockAddrBits-1:0] memBlockAddr,
        input  logic                     memValid,
        input  logic [BlockBits-1:0]     memData
);

        // Controller to arrays
        logic                     ren;
        logic                     memWen;
        logic [BlockAddrBits-1:0] blockAddr;
        logic [BlockBits-1:0]     dataIn;

        // Arrays to controller
        logic                     hit;
        logic [BlockBits-1:0]     dataOut;

        iCacheCtrl #(
                .NumSets (NumSets),
                .NumWays (NumWays)
        ) u_ctrl (
                .clk          (clk),
                .arstN        (arstN),
                .fetchReq     (fetchReq),
                .fetchAddr    (fetchAddr),
                .fetchReady   (fetchReady),
                .instrValid   (instrValid),
                .instr        (instr),
                .instrHit     (instrHit),
                .ren          (ren),
                .memWen       (memWen),
                .blockAddr    (blockAddr),
                .dataIn       (dataIn),
                .hit          (hit),
                .dataOut      (dataOut),
                .memReq       (memReq),
                .memBlockAddr (memBlockAddr),
                .memValid     (memValid),
                .memData      (memData)
        );

        iCacheSram #(
                .NumSets (NumSets),
                .NumWays (NumWays)
        ) u_sram (
                .clk       (clk),
                .arstN     (arstN),
                .ren       (ren),
                .memWen    (memWen),
                .blockAddr (blockAddr),
                .dataIn    (dataIn),
                .hit       (hit),
                .dataOut   (dataOut)
        );

endmodule

`default_nettype wire

//--- iMemModel.sv
// Instruction memory responder that returns a fixed block pattern after a random delay
`timescale 1ns/100ps
`default_nettype none

module iMemModel
        import iCachePkg::*;
#(
        parameter logic [31:0] Seed = 32'h262c788e
) (
        input  logic                     clk,
        input  logic                     arstN,
        input  logic                     memReq,
        input  logic [BlockAddrBits-1:0] memBlockAddr,
        output logic                     memValid,
        output logic [BlockBits-1:0]     memData
);

        logic        busy;
        logic [3:0]  waitCnt;
        logic [31:0] rngState;

        // Linear congruential step
        function automatic logic [31:0] lcgStep(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        // Each word carries its own address and the inverse of it
        function automatic logic [BlockBits-1:0] readBlock(input logic [BlockAddrBits-1:0] b);
                logic [BlockBits-1:0] blk;
                logic [AddrBits-1:0]  a;
                for (int i = 0; i < BlockWords; i++) begin
                        a = {b, OffsetBits'(i)};
                        blk[i*WordBits +: WordBits] = {6'b101101, a, ~a, 6'b010011};
                end
                return blk;
        endfunction

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        busy     <= 1'b0;
                        waitCnt  <= '0;
                        memValid <= 1'b0;
                        memData  <= '0;
                        rngState <= Seed;
                end else begin
                        memValid <= 1'b0;
                        // New request, delay of 1 to 8 cycles from the top bits
                        if (!busy && memReq && !memValid) begin
                                busy     <= 1'b1;
                                waitCnt  <= 4'(rngState[30:28]) + 4'd1;
                                rngState <= lcgStep(rngState);
                        end else if (busy) begin
                                if (waitCnt == 4'd1) begin
                                        busy     <= 1'b0;
                                        memValid <= 1'b1;
                                        memData  <= readBlock(memBlockAddr);
                                end
                                waitCnt <= waitCnt - 4'd1;
                        end
                end
        end

endmodule

`default_nettype wire
